// ==== bench/cpuControlTb.sv ====
`timescale 1ns/1ps
`include "cpuControl_macros.svh"

module cpuControlTb;

    typedef logic [20:0] strobes_t; // Gra in msb down to Halt in lsb

    localparam int ClockHalf = 50; // 100 ns period
    localparam int DriveDelay = 5; // inputs change this long after the rising edge
    localparam int ResetHold = 8;
    localparam int HaltHold = 16; // halted cycles watched
    localparam int SeqCycles = 9 * 6 + 2 * 6 + 3 * 6 + 2 * 8 + 2 * 8 // alu, imm, ld/st, br
        + 4 + 5 + 3 + 3 + HaltHold + 3 + 3; // jr, jal, illegal, halt, fetches after reset
    localparam int ResetCycles = 2 * (ResetHold + 2); // two resets, each plus release and clear
    localparam int CycleLimit = 2 * (SeqCycles + ResetCycles);
    localparam cpuControlPkg::opcode_t IllegalOp = 5'b11111; // no instruction uses it

    localparam strobes_t GraBit = 21'h100000;
    localparam strobes_t GrbBit = 21'h080000;
    localparam strobes_t GrcBit = 21'h040000;
    localparam strobes_t RinBit = 21'h020000;
    localparam strobes_t RoutBit = 21'h010000;
    localparam strobes_t CoutBit = 21'h008000;
    localparam strobes_t PcInBit = 21'h004000;
    localparam strobes_t PcOutBit = 21'h002000;
    localparam strobes_t IncPcBit = 21'h001000;
    localparam strobes_t IrInBit = 21'h000800;
    localparam strobes_t MarInBit = 21'h000400;
    localparam strobes_t MdrInBit = 21'h000200;
    localparam strobes_t MdrOutBit = 21'h000100;
    localparam strobes_t ReadBit = 21'h000080;
    localparam strobes_t WriteBit = 21'h000040;
    localparam strobes_t YInBit = 21'h000020;
    localparam strobes_t ZInBit = 21'h000010;
    localparam strobes_t ZLowOutBit = 21'h000008;
    localparam strobes_t ConInBit = 21'h000004;
    localparam strobes_t ClearBit = 21'h000002;
    localparam strobes_t HaltBit = 21'h000001;
    localparam strobes_t Fetch0Word = PcOutBit | MarInBit | IncPcBit | ZInBit;
    localparam strobes_t Fetch1Word = ReadBit | MdrInBit;
    localparam strobes_t Fetch2Word = MdrOutBit | IrInBit;

    logic Clock;
    logic Reset;
    cpuControlPkg::instrWord_t Ir;
    logic ConFlag;
    logic Gra, Grb, Grc, Rin, Rout, Cout, PcIn, PcOut, IncPc, IrIn, MarIn;
    logic MdrIn, MdrOut, Read, Write, YIn, ZIn, ZLowOut, ConIn, Clear, Halt;
    cpuControlPkg::aluOp_t AluOp;
    strobes_t observed; // all strobes in one word
    int cycleCount;

    cpuControl u_dut (.*);

    assign observed = {Gra, Grb, Grc, Rin, Rout, Cout, PcIn, PcOut, IncPc, IrIn, MarIn,
                       MdrIn, MdrOut, Read, Write, YIn, ZIn, ZLowOut, ConIn, Clear, Halt};

    always #ClockHalf Clock = ~Clock;

    always @(posedge Clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            stopRun($sformatf("timeout after %0d cycles, the tests did not finish", cycleCount));
        end
    end

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareStrobes(input string where, input strobes_t expected,
                                  input strobes_t actual);
        if (actual !== expected) begin
            stopRun($sformatf("CHECK FAILED strobes at %s: expected %h, got %h",
                              where, expected, actual));
        end
    endtask

    task automatic compareAluOp(input string where, input cpuControlPkg::aluOp_t expected,
                                input cpuControlPkg::aluOp_t actual);
        if (actual !== expected) begin
            stopRun($sformatf("CHECK FAILED AluOp at %s: expected %h, got %h",
                              where, expected, actual));
        end
    endtask

    // sample mid-cycle, then move to the next drive point
    task automatic checkCycle(input string where, input strobes_t expWord,
                              input cpuControlPkg::aluOp_t expAlu);
        @(negedge Clock);
        if (Read && Write) stopRun($sformatf("Read and Write both high at %s", where));
        compareStrobes(where, expWord, observed);
        compareAluOp(where, expAlu, AluOp);
        @(posedge Clock);
        #DriveDelay;
    endtask

    function automatic cpuControlPkg::instrWord_t makeIr(input cpuControlPkg::opcode_t op);
        return {op, 27'($urandom)}; // operand fields are don't care
    endfunction

    function automatic int stepCount(input cpuControlPkg::instrClass_t cls);
        case (cls)
            cpuControlPkg::ALU3, cpuControlPkg::ALUIMM, cpuControlPkg::ALU1: return 3;
            cpuControlPkg::LOAD, cpuControlPkg::STORE, cpuControlPkg::BRANCH: return 5;
            cpuControlPkg::JR: return 1;
            cpuControlPkg::JAL: return 2;
            default: return 0; // halt, illegal
        endcase
    endfunction

    // expected strobes of one execute step
    function automatic strobes_t execWord(input cpuControlPkg::instrClass_t cls, input int step,
                                          input logic flag);
        strobes_t w;
        logic isAlu3;
        logic isLoad;
        w = '0;
        isAlu3 = (cls == cpuControlPkg::ALU3);
        isLoad = (cls == cpuControlPkg::LOAD);
        case (cls)
            cpuControlPkg::ALU3, cpuControlPkg::ALUIMM, cpuControlPkg::ALU1: begin
                case (step)
                    1: w = GrbBit | RoutBit | YInBit;
                    2: w = ZInBit | (isAlu3 ? (GrcBit | RoutBit) : '0)
                           | ((cls == cpuControlPkg::ALUIMM) ? CoutBit : '0);
                    3: w = ZLowOutBit | GraBit | RinBit;
                    default: ;
                endcase
            end
            cpuControlPkg::LOAD, cpuControlPkg::STORE: begin
                case (step)
                    1: w = GrbBit | RoutBit | YInBit;
                    2: w = CoutBit | ZInBit; // address add
                    3: w = ZLowOutBit | MarInBit;
                    4: w = isLoad ? (ReadBit | MdrInBit) : (GraBit | RoutBit | MdrInBit);
                    5: w = isLoad ? (MdrOutBit | GraBit | RinBit) : WriteBit;
                    default: ;
                endcase
            end
            cpuControlPkg::BRANCH: begin
                case (step)
                    1: w = GraBit | RoutBit | ConInBit;
                    2: w = PcOutBit | YInBit;
                    3: w = CoutBit | ZInBit;
                    4: w = flag ? ZLowOutBit : IncPcBit; // taken vs fall through
                    5: w = flag ? PcInBit : '0;
                    default: ;
                endcase
            end
            cpuControlPkg::JR: w = (step == 1) ? (GraBit | RoutBit | PcInBit) : '0;
            cpuControlPkg::JAL: begin
                if (step == 1) w = PcOutBit | GrbBit | RinBit; // link
                if (step == 2) w = GraBit | RoutBit | PcInBit;
            end
            default: ;
        endcase
        return w;
    endfunction

    task automatic applyReset();
        Reset = 1'b1;
        repeat (ResetHold) checkCycle("reset held", '0, cpuControlPkg::NONE);
        Reset = 1'b0;
        checkCycle("reset release", '0, cpuControlPkg::NONE);
        checkCycle("reset cycle", PcInBit | ClearBit, cpuControlPkg::NONE);
    endtask

    task automatic runFetch(input string name, input cpuControlPkg::instrWord_t word);
        Ir = word; // next instruction shows up during fetch
        ConFlag = 1'($urandom);
        checkCycle({name, " fetch0"}, Fetch0Word, cpuControlPkg::NONE);
        ConFlag = 1'($urandom);
        checkCycle({name, " fetch1"}, Fetch1Word, cpuControlPkg::NONE);
        ConFlag = 1'($urandom);
        checkCycle({name, " fetch2"}, Fetch2Word, cpuControlPkg::NONE);
    endtask

    task automatic runInstr(input string name, input cpuControlPkg::opcode_t op,
                            input cpuControlPkg::instrClass_t cls,
                            input cpuControlPkg::aluOp_t alu, input logic branchFlag);
        int computeStep;
        computeStep = (cls == cpuControlPkg::BRANCH) ? 3 : 2; // step that writes z
        runFetch(name, makeIr(op));
        for (int s = 1; s <= stepCount(cls); s++) begin
            ConFlag = (cls == cpuControlPkg::BRANCH && s >= 4) ? branchFlag : 1'($urandom);
            checkCycle($sformatf("%s step %0d", name, s), execWord(cls, s, ConFlag),
                       (s == computeStep) ? alu : cpuControlPkg::NONE);
        end
    endtask

    task automatic resetTest();
        applyReset();
        runFetch("first fetch", makeIr(IllegalOp));
    endtask

    task automatic aluTest();
        runInstr("add", `CC_OP_ADD, cpuControlPkg::ALU3, cpuControlPkg::ADD, 1'b0);
        runInstr("sub", `CC_OP_SUB, cpuControlPkg::ALU3, cpuControlPkg::SUB, 1'b0);
        runInstr("and", `CC_OP_AND, cpuControlPkg::ALU3, cpuControlPkg::AND, 1'b0);
        runInstr("or", `CC_OP_OR, cpuControlPkg::ALU3, cpuControlPkg::OR, 1'b0);
        runInstr("ror", `CC_OP_ROR, cpuControlPkg::ALU3, cpuControlPkg::ROR, 1'b0);
        runInstr("rol", `CC_OP_ROL, cpuControlPkg::ALU3, cpuControlPkg::ROL, 1'b0);
        runInstr("shr", `CC_OP_SHR, cpuControlPkg::ALU3, cpuControlPkg::SHR, 1'b0);
        runInstr("shra", `CC_OP_SHRA, cpuControlPkg::ALU3, cpuControlPkg::SHRA, 1'b0);
        runInstr("shl", `CC_OP_SHL, cpuControlPkg::ALU3, cpuControlPkg::SHL, 1'b0);
        runInstr("neg", `CC_OP_NEG, cpuControlPkg::ALU1, cpuControlPkg::NEG, 1'b0);
        runInstr("not", `CC_OP_NOT, cpuControlPkg::ALU1, cpuControlPkg::NOT, 1'b0);
    endtask

    task automatic immMemTest();
        runInstr("addi", `CC_OP_ADDI, cpuControlPkg::ALUIMM, cpuControlPkg::ADD, 1'b0);
        runInstr("andi", `CC_OP_ANDI, cpuControlPkg::ALUIMM, cpuControlPkg::AND, 1'b0);
        runInstr("ori", `CC_OP_ORI, cpuControlPkg::ALUIMM, cpuControlPkg::OR, 1'b0);
        runInstr("ld", `CC_OP_LD, cpuControlPkg::LOAD, cpuControlPkg::ADD, 1'b0);
        runInstr("st", `CC_OP_ST, cpuControlPkg::STORE, cpuControlPkg::ADD, 1'b0);
    endtask

    task automatic branchTest();
        runInstr("br taken", `CC_OP_BR, cpuControlPkg::BRANCH, cpuControlPkg::ADD, 1'b1);
        runInstr("br not taken", `CC_OP_BR, cpuControlPkg::BRANCH, cpuControlPkg::ADD, 1'b0);
    endtask

    task automatic jumpTest();
        runInstr("jr", `CC_OP_JR, cpuControlPkg::JR, cpuControlPkg::NONE, 1'b0);
        runInstr("jal", `CC_OP_JAL, cpuControlPkg::JAL, cpuControlPkg::NONE, 1'b0);
        runFetch("illegal", makeIr(IllegalOp)); // next fetch must follow at once
    endtask

    task automatic haltTest();
        runInstr("halt", `CC_OP_HALT, cpuControlPkg::HALT, cpuControlPkg::NONE, 1'b0);
        repeat (HaltHold) begin
            Ir = makeIr(cpuControlPkg::opcode_t'($urandom)); // ignored while halted
            ConFlag = 1'($urandom);
            checkCycle("halted", HaltBit, cpuControlPkg::NONE);
        end
        applyReset();
        runFetch("restart", makeIr(IllegalOp));
    endtask

    initial begin
        Clock = 1'b0;
        Reset = 1'b1;
        Ir = '0;
        ConFlag = 1'b0;
        cycleCount = 0;
        void'($urandom(51)); // one seed for the run
        resetTest();
        aluTest();
        immMemTest();
        branchTest();
        jumpTest();
        haltTest();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== cpuControl.f ====
+incdir+source
source/cpuControlPkg.sv
source/microStepIf.sv
source/opcodeDecoder.sv
source/stepSequencer.sv
source/controlWordGen.sv
source/cpuControl.sv
bench/cpuControlTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the cpuControl testbench with Verilator, then judge the log
verilator --binary --timing --assert -j 0 --top-module cpuControlTb -f cpuControl.f \
    > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/VcpuControlTb > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation ended without a pass line"; exit 1; }
echo "simulation passed"
exit 0

// ==== source/controlWordGen.sv ====
`timescale 1ns/1ps

module controlWordGen (
    microStepIf.generator micro,
    input logic ConFlag, // condition flip-flop from datapath
    output logic Gra, // register select a
    output logic Grb,
    output logic Grc,
    output logic Rin, // selected register loads bus
    output logic Rout, // selected register drives bus
    output logic Cout, // sign-extended constant onto bus
    output logic PcIn,
    output logic PcOut,
    output logic IncPc,
    output logic IrIn,
    output logic MarIn,
    output logic MdrIn,
    output logic MdrOut,
    output logic Read,
    output logic Write,
    output logic YIn,
    output logic ZIn,
    output logic ZLowOut,
    output logic ConIn, // latch branch condition
    output logic Clear,
    output logic Halt,
    output cpuControlPkg::aluOp_t AluOp
);

    localparam cpuControlPkg::step_t step1 = cpuControlPkg::step_t'(1);
    localparam cpuControlPkg::step_t step2 = cpuControlPkg::step_t'(2);
    localparam cpuControlPkg::step_t step3 = cpuControlPkg::step_t'(3);
    localparam cpuControlPkg::step_t step4 = cpuControlPkg::step_t'(4);
    localparam cpuControlPkg::step_t step5 = cpuControlPkg::step_t'(5);

    logic isLoad; // load vs store share steps 1 to 3

    assign isLoad = (micro.instrClass == cpuControlPkg::LOAD);

    always_comb begin
        Gra = 1'b0; // everything idle unless a step asks
        Grb = 1'b0;
        Grc = 1'b0;
        Rin = 1'b0;
        Rout = 1'b0;
        Cout = 1'b0;
        PcIn = 1'b0;
        PcOut = 1'b0;
        IncPc = 1'b0;
        IrIn = 1'b0;
        MarIn = 1'b0;
        MdrIn = 1'b0;
        MdrOut = 1'b0;
        Read = 1'b0;
        Write = 1'b0;
        YIn = 1'b0;
        ZIn = 1'b0;
        ZLowOut = 1'b0;
        ConIn = 1'b0;
        Clear = 1'b0;
        Halt = 1'b0;
        AluOp = cpuControlPkg::NONE; // only the compute step passes the decoded op
        case (micro.phase)
            cpuControlPkg::RESET: begin
                PcIn = (micro.step != '0); // pc cleared through Clear
                Clear = (micro.step != '0);
            end
            cpuControlPkg::FETCH0: begin
                PcOut = 1'b1; // pc to mar
                MarIn = 1'b1;
                IncPc = 1'b1;
                ZIn = 1'b1; // pc+1 lands in z
            end
            cpuControlPkg::FETCH1: begin
                Read = 1'b1; // instruction into mdr
                MdrIn = 1'b1;
            end
            cpuControlPkg::FETCH2: begin
                MdrOut = 1'b1; // mdr to ir
                IrIn = 1'b1;
            end
            cpuControlPkg::EXEC: begin
                case (micro.instrClass)
                    cpuControlPkg::ALU3, cpuControlPkg::ALUIMM, cpuControlPkg::ALU1: begin
                        case (micro.step)
                            step1: begin
                                Grb = 1'b1; // rb into y
                                Rout = 1'b1;
                                YIn = 1'b1;
                            end
                            step2: begin
                                Grc = (micro.instrClass == cpuControlPkg::ALU3); // rc operand
                                Rout = (micro.instrClass == cpuControlPkg::ALU3);
                                Cout = (micro.instrClass == cpuControlPkg::ALUIMM); // imm
                                AluOp = micro.aluOp;
                                ZIn = 1'b1;
                            end
                            step3: begin
                                ZLowOut = 1'b1; // result to ra
                                Gra = 1'b1;
                                Rin = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    cpuControlPkg::LOAD, cpuControlPkg::STORE: begin
                        case (micro.step)
                            step1: begin
                                Grb = 1'b1; // base register into y
                                Rout = 1'b1;
                                YIn = 1'b1;
                            end
                            step2: begin
                                Cout = 1'b1; // base + offset
                                AluOp = micro.aluOp;
                                ZIn = 1'b1;
                            end
                            step3: begin
                                ZLowOut = 1'b1; // effective address to mar
                                MarIn = 1'b1;
                            end
                            step4: begin
                                Read = isLoad; // load reads memory
                                Gra = !isLoad; // store puts ra in mdr
                                Rout = !isLoad;
                                MdrIn = 1'b1;
                            end
                            step5: begin
                                MdrOut = isLoad; // loaded word to ra
                                Gra = isLoad;
                                Rin = isLoad;
                                Write = !isLoad; // mdr to memory
                            end
                            default: ;
                        endcase
                    end
                    cpuControlPkg::BRANCH: begin
                        case (micro.step)
                            step1: begin
                                Gra = 1'b1; // ra tested by con logic
                                Rout = 1'b1;
                                ConIn = 1'b1;
                            end
                            step2: begin
                                PcOut = 1'b1;
                                YIn = 1'b1;
                            end
                            step3: begin
                                Cout = 1'b1; // pc + offset
                                AluOp = micro.aluOp;
                                ZIn = 1'b1;
                            end
                            step4: begin
                                ZLowOut = ConFlag; // taken, target on bus
                                IncPc = !ConFlag; // not taken
                            end
                            step5: PcIn = ConFlag;
                            default: ;
                        endcase
                    end
                    cpuControlPkg::JR: begin
                        Gra = (micro.step == step1); // ra into pc
                        Rout = (micro.step == step1);
                        PcIn = (micro.step == step1);
                    end
                    cpuControlPkg::JAL: begin
                        PcOut = (micro.step == step1); // return address to link reg
                        Grb = (micro.step == step1);
                        Rin = (micro.step == step1);
                        Gra = (micro.step == step2); // then jump through ra
                        Rout = (micro.step == step2);
                        PcIn = (micro.step == step2);
                    end
                    default: ;
                endcase
            end
            cpuControlPkg::HALTED: Halt = 1'b1;
            default: ;
        endcase
    end

    // checked on settled strobes at each step boundary
    readWriteExclusive: assert property (@(posedge micro.Clock) !(Read && Write));

    regInOutExclusive: assert property (@(posedge micro.Clock) !(Rin && Rout));

endmodule

// ==== source/cpuControl.sv ====
`timescale 1ns/1ps

module cpuControl (
    input logic Clock,
    input logic Reset,
    input cpuControlPkg::instrWord_t Ir, // held stable through execute
    input logic ConFlag,
    output logic Gra,
    output logic Grb,
    output logic Grc,
    output logic Rin,
    output logic Rout,
    output logic Cout,
    output logic PcIn,
    output logic PcOut,
    output logic IncPc,
    output logic IrIn,
    output logic MarIn,
    output logic MdrIn,
    output logic MdrOut,
    output logic Read,
    output logic Write,
    output logic YIn,
    output logic ZIn,
    output logic ZLowOut,
    output logic ConIn,
    output logic Clear,
    output logic Halt,
    output cpuControlPkg::aluOp_t AluOp
);

    microStepIf micro (.Clock(Clock)); // class, op, phase, step

    opcodeDecoder opDecode (
        .Ir(Ir),
        .micro(micro)
    );

    stepSequencer stepSeq (
        .Clock(Clock),
        .Reset(Reset),
        .micro(micro)
    );

    controlWordGen ctrlGen (
        .micro(micro),
        .ConFlag(ConFlag),
        .Gra(Gra), .Grb(Grb), .Grc(Grc),
        .Rin(Rin), .Rout(Rout), .Cout(Cout),
        .PcIn(PcIn), .PcOut(PcOut), .IncPc(IncPc),
        .IrIn(IrIn), .MarIn(MarIn),
        .MdrIn(MdrIn), .MdrOut(MdrOut),
        .Read(Read), .Write(Write),
        .YIn(YIn), .ZIn(ZIn), .ZLowOut(ZLowOut),
        .ConIn(ConIn), .Clear(Clear), .Halt(Halt),
        .AluOp(AluOp)
    );

endmodule

// ==== source/cpuControlPkg.sv ====
`include "cpuControl_macros.svh"

package cpuControlPkg;

    typedef logic [`CC_INSTR_WIDTH-1:0] instrWord_t; // raw IR contents
    typedef logic [`CC_OP_MSB-`CC_OP_LSB:0] opcode_t; // IR[31:27]
    typedef logic [`CC_STEP_WIDTH-1:0] step_t; // execute step, first step is 1

    // one code per ALU function, NONE when the ALU result is not wanted
    typedef enum logic [`CC_ALUOP_WIDTH-1:0] {
        NONE,
        ADD,
        SUB,
        AND,
        OR,
        ROR,
        ROL,
        SHR,
        SHRA, // arithmetic right shift
        SHL,
        NEG,
        NOT
    } aluOp_t;

    typedef enum logic [`CC_CLASS_WIDTH-1:0] {
        ALU3, // ra = rb op rc
        ALUIMM, // ra = rb op c
        ALU1, // ra = op rb
        LOAD,
        STORE,
        BRANCH,
        JR,
        JAL,
        HALT,
        ILLEGAL // anything not decoded
    } instrClass_t;

    typedef enum logic [`CC_PHASE_WIDTH-1:0] {
        RESET,
        FETCH0, // pc to mar, pc increment
        FETCH1, // memory read into mdr
        FETCH2, // mdr into ir
        EXEC, // class dependent steps
        HALTED
    } phase_t;

endpackage

// ==== source/cpuControl_macros.svh ====
`ifndef CPU_CONTROL_MACROS_SVH
`define CPU_CONTROL_MACROS_SVH

`define CC_INSTR_WIDTH 32 // full IR width
`define CC_OP_MSB 31 // opcode field top bit
`define CC_OP_LSB 27 // opcode field bottom bit
`define CC_STEP_WIDTH 3 // enough for the 5-step classes
`define CC_ALUOP_WIDTH 4
`define CC_CLASS_WIDTH 4
`define CC_PHASE_WIDTH 3

`define CC_OP_LD 5'b00000 // load
`define CC_OP_ST 5'b00010 // store
`define CC_OP_ADD 5'b00011
`define CC_OP_SUB 5'b00100
`define CC_OP_AND 5'b00101
`define CC_OP_OR 5'b00110
`define CC_OP_ROR 5'b00111
`define CC_OP_ROL 5'b01000
`define CC_OP_SHR 5'b01001
`define CC_OP_SHRA 5'b01010
`define CC_OP_SHL 5'b01011
`define CC_OP_ADDI 5'b01100
`define CC_OP_ANDI 5'b01101
`define CC_OP_ORI 5'b01110
`define CC_OP_NEG 5'b10001
`define CC_OP_NOT 5'b10010
`define CC_OP_BR 5'b10011 // conditional branch
`define CC_OP_JAL 5'b10100
`define CC_OP_JR 5'b10101
`define CC_OP_HALT 5'b11011 // otherwise unused code

`define CC_STEPS_ALU 3 // alu3, aluimm, alu1
`define CC_STEPS_MEM 5 // load and store
`define CC_STEPS_BR 5
`define CC_STEPS_JR 1
`define CC_STEPS_JAL 2

`endif

// ==== source/microStepIf.sv ====
`timescale 1ns/1ps

// decoded instruction plus sequencer position, shared by the three control blocks
interface microStepIf (
    input logic Clock // only the generator checks sample on it
);

    cpuControlPkg::instrClass_t instrClass; // from decoder
    cpuControlPkg::aluOp_t aluOp; // from decoder
    cpuControlPkg::phase_t phase; // from sequencer
    cpuControlPkg::step_t step; // from sequencer

    modport decoder (
        output instrClass,
        output aluOp
    );

    modport sequencer (
        input instrClass, // picks next phase after fetch2
        output phase,
        output step
    );

    modport generator (
        input Clock,
        input instrClass,
        input aluOp,
        input phase,
        input step
    );

endinterface

// ==== source/opcodeDecoder.sv ====
`timescale 1ns/1ps
`include "cpuControl_macros.svh"

module opcodeDecoder (
    input cpuControlPkg::instrWord_t Ir, // instruction register from datapath
    microStepIf.decoder micro
);

    cpuControlPkg::opcode_t opcode;

    assign opcode = Ir[`CC_OP_MSB:`CC_OP_LSB]; // only the opcode field matters here

    // instruction class, drives step count and strobe pattern
    always_comb begin
        case (opcode)
            `CC_OP_ADD, `CC_OP_SUB, `CC_OP_AND,
            `CC_OP_OR, `CC_OP_ROR, `CC_OP_ROL,
            `CC_OP_SHR, `CC_OP_SHRA, `CC_OP_SHL: begin
                micro.instrClass = cpuControlPkg::ALU3; // register-register ops
            end
            `CC_OP_ADDI, `CC_OP_ANDI, `CC_OP_ORI: begin
                micro.instrClass = cpuControlPkg::ALUIMM; // constant from ir
            end
            `CC_OP_NEG, `CC_OP_NOT: begin
                micro.instrClass = cpuControlPkg::ALU1; // single operand
            end
            `CC_OP_LD: micro.instrClass = cpuControlPkg::LOAD;
            `CC_OP_ST: micro.instrClass = cpuControlPkg::STORE;
            `CC_OP_BR: micro.instrClass = cpuControlPkg::BRANCH;
            `CC_OP_JR: micro.instrClass = cpuControlPkg::JR;
            `CC_OP_JAL: micro.instrClass = cpuControlPkg::JAL;
            `CC_OP_HALT: micro.instrClass = cpuControlPkg::HALT;
            default: micro.instrClass = cpuControlPkg::ILLEGAL; // dropped or free codes
        endcase
    end

    // alu function; address and branch offset math reuse ADD
    always_comb begin
        case (opcode)
            `CC_OP_ADD, `CC_OP_ADDI,
            `CC_OP_LD, `CC_OP_ST, `CC_OP_BR: begin
                micro.aluOp = cpuControlPkg::ADD; // base + offset for ld/st/br
            end
            `CC_OP_SUB: micro.aluOp = cpuControlPkg::SUB;
            `CC_OP_AND, `CC_OP_ANDI: micro.aluOp = cpuControlPkg::AND;
            `CC_OP_OR, `CC_OP_ORI: micro.aluOp = cpuControlPkg::OR;
            `CC_OP_ROR: micro.aluOp = cpuControlPkg::ROR;
            `CC_OP_ROL: micro.aluOp = cpuControlPkg::ROL;
            `CC_OP_SHR: micro.aluOp = cpuControlPkg::SHR;
            `CC_OP_SHRA: micro.aluOp = cpuControlPkg::SHRA;
            `CC_OP_SHL: micro.aluOp = cpuControlPkg::SHL;
            `CC_OP_NEG: micro.aluOp = cpuControlPkg::NEG;
            `CC_OP_NOT: micro.aluOp = cpuControlPkg::NOT;
            default: micro.aluOp = cpuControlPkg::NONE; // jumps, halt, illegal
        endcase
    end

endmodule

// ==== source/stepSequencer.sv ====
`timescale 1ns/1ps
`include "cpuControl_macros.svh"

module stepSequencer (
    input logic Clock,
    input logic Reset,
    microStepIf.sequencer micro
);

    cpuControlPkg::phase_t phase;
    cpuControlPkg::step_t step;
    cpuControlPkg::step_t lastStep; // final execute step of current class

    // step count per class
    always_comb begin
        case (micro.instrClass)
            cpuControlPkg::ALU3, cpuControlPkg::ALUIMM, cpuControlPkg::ALU1: begin
                lastStep = cpuControlPkg::step_t'(`CC_STEPS_ALU);
            end
            cpuControlPkg::LOAD, cpuControlPkg::STORE: begin
                lastStep = cpuControlPkg::step_t'(`CC_STEPS_MEM);
            end
            cpuControlPkg::BRANCH: lastStep = cpuControlPkg::step_t'(`CC_STEPS_BR);
            cpuControlPkg::JR: lastStep = cpuControlPkg::step_t'(`CC_STEPS_JR);
            cpuControlPkg::JAL: lastStep = cpuControlPkg::step_t'(`CC_STEPS_JAL);
            default: lastStep = '0; // halt and illegal skip EXEC
        endcase
    end

    // step 0 in RESET means still held or just released, step 1 is the clocked reset cycle
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            phase <= cpuControlPkg::RESET;
            step <= '0;
        end else begin
            case (phase)
                cpuControlPkg::RESET: begin
                    if (step == '0) begin
                        step <= cpuControlPkg::step_t'(1); // pc clear cycle next
                    end else begin
                        phase <= cpuControlPkg::FETCH0;
                        step <= '0;
                    end
                end
                cpuControlPkg::FETCH0: phase <= cpuControlPkg::FETCH1;
                cpuControlPkg::FETCH1: phase <= cpuControlPkg::FETCH2;
                cpuControlPkg::FETCH2: begin
                    // opcode must be on Ir by the end of fetch2
                    case (micro.instrClass)
                        cpuControlPkg::ILLEGAL: phase <= cpuControlPkg::FETCH0; // skip it
                        cpuControlPkg::HALT: phase <= cpuControlPkg::HALTED;
                        default: begin
                            phase <= cpuControlPkg::EXEC;
                            step <= cpuControlPkg::step_t'(1);
                        end
                    endcase
                end
                cpuControlPkg::EXEC: begin
                    if (step == lastStep) begin
                        phase <= cpuControlPkg::FETCH0; // next instruction, pc kept
                        step <= '0;
                    end else begin
                        step <= step + cpuControlPkg::step_t'(1);
                    end
                end
                default: phase <= phase; // HALTED waits for Reset
            endcase
        end
    end

    assign micro.phase = phase;
    assign micro.step = step;

    // Ir changing mid-instruction would shrink lastStep under a running count
    execStepInRange: assert property (@(posedge Clock) disable iff (Reset)
        phase == cpuControlPkg::EXEC |-> step != '0 && step <= lastStep);

    haltedIsSticky: assert property (@(posedge Clock) disable iff (Reset)
        phase == cpuControlPkg::HALTED |=> phase == cpuControlPkg::HALTED);

endmodule
